// ==== design/forget_gate_pkg.sv ====
//////////////////////////////////////////////////
// Forget gate shared definitions
// Word widths, operand memory layout and the
// fixed-point types used by every block
//////////////////////////////////////////////////

`default_nettype none

package forget_gate_pkg;

  // Word and accumulator widths
  localparam int DATA_W = 16;
  localparam int ACC_W  = 32;

  // Problem size limits
  localparam int MAX_L  = 8;
  localparam int MAX_N  = 16;

  //////////////////////////////////////////////////
  // Operand memory map
  //////////////////////////////////////////////////
  localparam int ADDR_W  = 8;
  // Weight (l, n) at l*MAX_N + n
  localparam int W_BASE  = 0;
  // Input element n
  localparam int IN_BASE = 128;
  // Bias of row l
  localparam int B_BASE  = 144;

  // Q8.8 operand and Q16.16 accumulator
  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  typedef logic [ADDR_W-1:0]         addr_t;
  typedef logic [$clog2(MAX_L)-1:0]  row_t;
  // Counts run 1..MAX, one extra bit
  typedef logic [$clog2(MAX_N):0]    len_t;
  typedef logic [$clog2(MAX_L):0]    cnt_t;

endpackage

`default_nettype wire

// ==== design/operand_memory.sv ====
//////////////////////////////////////////////////
// Operand memory
// Single-port synchronous RAM for weights,
// input vector and biases, one-cycle read
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module operand_memory (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    en,
  input  wire                    we,
  input  forget_gate_pkg::addr_t addr,
  input  forget_gate_pkg::data_t wdata,
  output forget_gate_pkg::data_t rdata
);

  // Full address space
  localparam int DEPTH = 2 ** forget_gate_pkg::ADDR_W;

  forget_gate_pkg::data_t mem [DEPTH];

  // Write port, array contents kept across reset
  always_ff @(posedge CLK) begin
    if (en && we) begin
      mem[addr] <= wdata;
    end
  end

  // Registered read on enabled non-write cycles
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rdata <= '0;
    end else if (en && !we) begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== design/memory_arbiter.sv ====
//////////////////////////////////////////////////
// Operand memory arbiter
// Fixed priority host > bias stage > dot engine,
// routes read-valid back to the granted reader
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module memory_arbiter (
  input  wire                    CLK,
  input  wire                    RST,
  // Host write port, always wins
  input  wire                    host_req,
  input  forget_gate_pkg::addr_t host_addr,
  input  forget_gate_pkg::data_t host_wdata,
  // Bias stage reads
  input  wire                    bias_req,
  input  forget_gate_pkg::addr_t bias_addr,
  // Dot engine reads
  input  wire                    dot_req,
  input  forget_gate_pkg::addr_t dot_addr,
  output logic                   bias_gnt,
  output logic                   dot_gnt,
  output logic                   bias_rvalid,
  output logic                   dot_rvalid,
  // Memory side
  output logic                   mem_en,
  output logic                   mem_we,
  output forget_gate_pkg::addr_t mem_addr,
  output forget_gate_pkg::data_t mem_wdata
);

  //////////////////////////////////////////////////
  // Grant decision, same cycle
  //////////////////////////////////////////////////
  assign bias_gnt = bias_req && !host_req;
  assign dot_gnt  = dot_req && !host_req && !bias_req;

  assign mem_en    = host_req || bias_req || dot_req;
  assign mem_we    = host_req;
  assign mem_wdata = host_wdata;

  // Address of the winner
  always_comb begin
    if (host_req) begin
      mem_addr = host_addr;
    end else if (bias_req) begin
      mem_addr = bias_addr;
    end else begin
      mem_addr = dot_addr;
    end
  end

  // Remember the granted reader for the return word
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bias_rvalid <= 1'b0;
      dot_rvalid  <= 1'b0;
    end else begin
      bias_rvalid <= bias_gnt;
      dot_rvalid  <= dot_gnt;
    end
  end

endmodule

`default_nettype wire

// ==== design/dot_product_engine.sv ====
//////////////////////////////////////////////////
// Dot product engine
// Multiply-accumulate of one weight row against
// the input vector, weight and input read in turn
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dot_product_engine (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    row_start,
  input  forget_gate_pkg::row_t  row_sel,
  input  forget_gate_pkg::len_t  len,
  input  wire                    take,
  input  wire                    gnt,
  input  wire                    rvalid,
  input  forget_gate_pkg::data_t rdata,
  output logic                   req,
  output forget_gate_pkg::addr_t addr,
  output logic                   result_valid,
  output forget_gate_pkg::acc_t  acc_out,
  output forget_gate_pkg::row_t  result_row,
  output logic                   busy
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_W,
    S_X,
    S_LAST,
    S_DONE
  } state_t;

  state_t                 state;
  forget_gate_pkg::len_t  idx;
  forget_gate_pkg::len_t  len_q;
  forget_gate_pkg::row_t  row_q;
  forget_gate_pkg::data_t weight_q;
  forget_gate_pkg::acc_t  acc_q;
  logic                   last_elem;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////
  assign req       = (state == S_W) || (state == S_X);
  assign busy      = (state != S_IDLE);
  assign last_elem = (idx == len_q - forget_gate_pkg::len_t'(1));

  // Weight row stride is MAX_N
  always_comb begin
    if (state == S_W) begin
      addr = forget_gate_pkg::addr_t'(forget_gate_pkg::W_BASE
             + int'(row_q) * forget_gate_pkg::MAX_N + int'(idx));
    end else begin
      addr = forget_gate_pkg::addr_t'(forget_gate_pkg::IN_BASE + int'(idx));
    end
  end

  // Sequencing
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= S_IDLE;
      idx          <= '0;
      result_valid <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (row_start) begin
            idx   <= '0;
            state <= S_W;
          end
        end
        // Weight read, hold until granted
        S_W: begin
          if (gnt) begin
            state <= S_X;
          end
        end
        // Input read for the same element
        S_X: begin
          if (gnt) begin
            if (last_elem) begin
              state <= S_LAST;
            end else begin
              idx   <= idx + forget_gate_pkg::len_t'(1);
              state <= S_W;
            end
          end
        end
        // Last input word still in flight
        S_LAST: begin
          if (rvalid) begin
            result_valid <= 1'b1;
            state        <= S_DONE;
          end
        end
        // Hold result until the bias stage takes it
        S_DONE: begin
          if (take) begin
            result_valid <= 1'b0;
            state        <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  // Weight words only ever return while in S_X
  always_ff @(posedge CLK) begin
    if (state == S_IDLE && row_start) begin
      row_q <= row_sel;
      len_q <= len;
      acc_q <= '0;
    end else if (rvalid && state == S_X) begin
      weight_q <= rdata;
    end else if (rvalid) begin
      // Q8.8 x Q8.8 gives Q16.16, wraps mod 2^32
      acc_q <= acc_q + forget_gate_pkg::acc_t'(weight_q) * forget_gate_pkg::acc_t'(rdata);
    end
  end

  assign acc_out    = acc_q;
  assign result_row = row_q;

endmodule

`default_nettype wire

// ==== design/bias_logistic_unit.sv ====
//////////////////////////////////////////////////
// Bias and logistic stage
// Adds the row bias to the dot product and
// applies the hard sigmoid, one gate per row
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bias_logistic_unit (
  input  wire                    CLK,
  input  wire                    RST,
  input  wire                    result_valid,
  input  forget_gate_pkg::acc_t  acc_in,
  input  forget_gate_pkg::row_t  row_in,
  input  wire                    gnt,
  input  wire                    rvalid,
  input  forget_gate_pkg::data_t rdata,
  output logic                   take,
  output logic                   req,
  output forget_gate_pkg::addr_t addr,
  output forget_gate_pkg::data_t f_out,
  output forget_gate_pkg::row_t  f_index,
  output logic                   f_enable
);

  typedef enum logic [1:0] {
    B_IDLE,
    B_REQ,
    B_WAIT
  } state_t;

  state_t                state;
  forget_gate_pkg::acc_t acc_q;
  forget_gate_pkg::row_t row_q;
  forget_gate_pkg::acc_t sum;
  forget_gate_pkg::acc_t lin;
  forget_gate_pkg::data_t gate;

  // Accept only when idle, else engine holds its result
  assign take = (state == B_IDLE) && result_valid;
  assign req  = (state == B_REQ);
  assign addr = forget_gate_pkg::addr_t'(forget_gate_pkg::B_BASE + int'(row_q));

  //////////////////////////////////////////////////
  // Hard sigmoid, y = z/4 + 1/2 clamped to [0, 1]
  //////////////////////////////////////////////////
  always_comb begin
    // Bias Q8.8 aligned to Q16.16
    sum = acc_q + (forget_gate_pkg::acc_t'(rdata) <<< 8);
    // Q16.16 to Q8.8 is >>>8, /4 is two more
    lin = (sum >>> 10) + 32'sd128;
    if (lin < 0) begin
      gate = '0;
    end else if (lin > 256) begin
      gate = 16'sd256;
    end else begin
      gate = forget_gate_pkg::data_t'(lin);
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= B_IDLE;
      f_enable <= 1'b0;
    end else begin
      f_enable <= 1'b0;
      case (state)
        B_IDLE: begin
          if (take) begin
            state <= B_REQ;
          end
        end
        B_REQ: begin
          if (gnt) begin
            state <= B_WAIT;
          end
        end
        B_WAIT: begin
          if (rvalid) begin
            f_enable <= 1'b1;
            state    <= B_IDLE;
          end
        end
        default: state <= B_IDLE;
      endcase
    end
  end

  // Captured operands and registered gate
  always_ff @(posedge CLK) begin
    if (take) begin
      acc_q <= acc_in;
      row_q <= row_in;
    end
    if (state == B_WAIT && rvalid) begin
      f_out   <= gate;
      f_index <= row_q;
    end
  end

endmodule

`default_nettype wire

// ==== design/gate_controller.sv ====
//////////////////////////////////////////////////
// Gate controller
// Latches the run size, dispatches rows to the
// dot engine and signals READY when all are out
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gate_controller (
  input  wire                   CLK,
  input  wire                   RST,
  input  wire                   start,
  input  forget_gate_pkg::cnt_t size_l,
  input  forget_gate_pkg::len_t size_n,
  input  wire                   take,
  input  wire                   f_enable,
  output logic                  row_start,
  output forget_gate_pkg::row_t row_sel,
  output forget_gate_pkg::len_t len,
  output logic                  ready
);

  typedef enum logic {
    C_IDLE,
    C_RUN
  } state_t;

  state_t                state;
  forget_gate_pkg::cnt_t size_l_q;
  // Rows handed to the engine so far
  forget_gate_pkg::cnt_t issued;
  // Gates seen on the output
  forget_gate_pkg::cnt_t done_cnt;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= C_IDLE;
      size_l_q  <= '0;
      len       <= '0;
      issued    <= '0;
      done_cnt  <= '0;
      row_start <= 1'b0;
      row_sel   <= '0;
      ready     <= 1'b0;
    end else begin
      row_start <= 1'b0;
      ready     <= 1'b0;
      case (state)
        // START only honoured here
        C_IDLE: begin
          if (start) begin
            size_l_q  <= size_l;
            len       <= size_n;
            row_sel   <= '0;
            row_start <= 1'b1;
            issued    <= forget_gate_pkg::cnt_t'(1);
            done_cnt  <= '0;
            state     <= C_RUN;
          end
        end
        C_RUN: begin
          // Next row once the previous result left the engine
          if (take && issued < size_l_q) begin
            row_sel   <= forget_gate_pkg::row_t'(issued);
            row_start <= 1'b1;
            issued    <= issued + forget_gate_pkg::cnt_t'(1);
          end
          if (f_enable) begin
            done_cnt <= done_cnt + forget_gate_pkg::cnt_t'(1);
            // Last gate out, pulse READY next cycle
            if (done_cnt == size_l_q - forget_gate_pkg::cnt_t'(1)) begin
              ready <= 1'b1;
              state <= C_IDLE;
            end
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/forget_gate_top.sv ====
//////////////////////////////////////////////////
// Forget gate top level
// Controller, dot engine and bias stage sharing
// one operand memory through the arbiter
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module forget_gate_top (
  input  wire                    CLK,
  input  wire                    RST,
  // Host load port
  input  wire                    LOAD_ENABLE,
  input  forget_gate_pkg::addr_t LOAD_ADDR,
  input  forget_gate_pkg::data_t LOAD_DATA,
  // Run control
  input  wire                    START,
  input  forget_gate_pkg::cnt_t  SIZE_L_IN,
  input  forget_gate_pkg::len_t  SIZE_N_IN,
  // Results
  output forget_gate_pkg::data_t F_OUT,
  output forget_gate_pkg::row_t  F_OUT_INDEX,
  output logic                   F_OUT_ENABLE,
  output logic                   READY
);

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////
  // Controller to engine
  logic                   row_start;
  forget_gate_pkg::row_t  row_sel;
  forget_gate_pkg::len_t  row_len;
  // Engine to bias stage
  logic                   take;
  logic                   result_valid;
  forget_gate_pkg::acc_t  dot_acc;
  forget_gate_pkg::row_t  dot_row;
  // Arbiter peers
  logic                   dot_req;
  logic                   dot_gnt;
  logic                   dot_rvalid;
  forget_gate_pkg::addr_t dot_addr;
  logic                   bias_req;
  logic                   bias_gnt;
  logic                   bias_rvalid;
  forget_gate_pkg::addr_t bias_addr;
  // Memory port
  logic                   mem_en;
  logic                   mem_we;
  forget_gate_pkg::addr_t mem_addr;
  forget_gate_pkg::data_t mem_wdata;
  forget_gate_pkg::data_t mem_rdata;

  gate_controller u_gate_controller (
    .CLK       (CLK),
    .RST       (RST),
    .start     (START),
    .size_l    (SIZE_L_IN),
    .size_n    (SIZE_N_IN),
    .take      (take),
    .f_enable  (F_OUT_ENABLE),
    .row_start (row_start),
    .row_sel   (row_sel),
    .len       (row_len),
    .ready     (READY)
  );

  // Busy left for probing only
  dot_product_engine u_dot_product_engine (
    .CLK          (CLK),
    .RST          (RST),
    .row_start    (row_start),
    .row_sel      (row_sel),
    .len          (row_len),
    .take         (take),
    .gnt          (dot_gnt),
    .rvalid       (dot_rvalid),
    .rdata        (mem_rdata),
    .req          (dot_req),
    .addr         (dot_addr),
    .result_valid (result_valid),
    .acc_out      (dot_acc),
    .result_row   (dot_row),
    .busy         ()
  );

  bias_logistic_unit u_bias_logistic_unit (
    .CLK          (CLK),
    .RST          (RST),
    .result_valid (result_valid),
    .acc_in       (dot_acc),
    .row_in       (dot_row),
    .gnt          (bias_gnt),
    .rvalid       (bias_rvalid),
    .rdata        (mem_rdata),
    .take         (take),
    .req          (bias_req),
    .addr         (bias_addr),
    .f_out        (F_OUT),
    .f_index      (F_OUT_INDEX),
    .f_enable     (F_OUT_ENABLE)
  );

  memory_arbiter u_memory_arbiter (
    .CLK         (CLK),
    .RST         (RST),
    .host_req    (LOAD_ENABLE),
    .host_addr   (LOAD_ADDR),
    .host_wdata  (LOAD_DATA),
    .bias_req    (bias_req),
    .bias_addr   (bias_addr),
    .dot_req     (dot_req),
    .dot_addr    (dot_addr),
    .bias_gnt    (bias_gnt),
    .dot_gnt     (dot_gnt),
    .bias_rvalid (bias_rvalid),
    .dot_rvalid  (dot_rvalid),
    .mem_en      (mem_en),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata)
  );

  operand_memory u_operand_memory (
    .CLK   (CLK),
    .RST   (RST),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== sim/forget_gate_tb.sv ====
//////////////////////////////////////////////////
// Forget gate testbench
// Directed runs against a Q8.8 reference model,
// host stalls, clamping and back-to-back runs
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module forget_gate_tb;

  logic                   CLK;
  logic                   RST;
  logic                   load_enable;
  forget_gate_pkg::addr_t load_addr;
  forget_gate_pkg::data_t load_data;
  logic                   start;
  forget_gate_pkg::cnt_t  size_l;
  forget_gate_pkg::len_t  size_n;
  forget_gate_pkg::data_t f_out;
  forget_gate_pkg::row_t  f_out_index;
  logic                   f_out_enable;
  logic                   ready;

  // Shadow of the operand memory
  forget_gate_pkg::data_t shadow [256];
  // Collected outputs
  forget_gate_pkg::data_t got_gate [$];
  forget_gate_pkg::row_t  got_index [$];
  int          ready_count;
  logic        ready_after_enable;
  logic        last_enable;
  int unsigned lcg_state;
  int          cycle_count;
  int          error_count;
  int          test_errors;
  int          check_count;
  int          test_count;
  logic        hammer;

  forget_gate_top u_forget_gate_top (
    .CLK          (CLK),
    .RST          (RST),
    .LOAD_ENABLE  (load_enable),
    .LOAD_ADDR    (load_addr),
    .LOAD_DATA    (load_data),
    .START        (start),
    .SIZE_L_IN    (size_l),
    .SIZE_N_IN    (size_n),
    .F_OUT        (f_out),
    .F_OUT_INDEX  (f_out_index),
    .F_OUT_ENABLE (f_out_enable),
    .READY        (ready)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  // Hard stop, longest runs plus loading sit far below this
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= 4000) begin
      $display("Timeout: run exceeded 4000 cycles without finishing");
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Output collector, sampled mid-cycle
  //////////////////////////////////////////////////
  always @(negedge CLK) begin
    if (!RST) begin
      if (f_out_enable) begin
        got_gate.push_back(f_out);
        got_index.push_back(f_out_index);
      end
      if (ready) begin
        ready_count        = ready_count + 1;
        ready_after_enable = last_enable;
      end
      last_enable = f_out_enable;
    end
  end

  // LCG, operands in -2.0..+2.0 Q8.8
  function automatic forget_gate_pkg::data_t rand_operand();
    int unsigned r;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    r = lcg_state >> 12;
    return forget_gate_pkg::data_t'(int'(r % 1025) - 512);
  endfunction

  // Reference: sum of products plus bias, z/4 + 1/2, clamp 0..1
  function automatic forget_gate_pkg::data_t expected_gate(input int row, input int n);
    longint total;
    int     z;
    int     y;
    int     k;
    total = 0;
    for (k = 0; k < n; k++) begin
      total += longint'(shadow[forget_gate_pkg::W_BASE + row * forget_gate_pkg::MAX_N + k])
             * longint'(shadow[forget_gate_pkg::IN_BASE + k]);
    end
    // Bias Q8.8 lifted to Q16.16
    total += longint'(shadow[forget_gate_pkg::B_BASE + row]) * 256;
    // Accumulator wraps at 32 bits
    z = int'(total);
    y = (z >>> 10) + 128;
    if (y < 0) y = 0;
    if (y > 256) y = 256;
    return forget_gate_pkg::data_t'(y);
  endfunction

  task automatic count_error();
    error_count++;
    test_errors++;
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_gate(input forget_gate_pkg::data_t got,
                            input forget_gate_pkg::data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      count_error();
      $display("[FAIL] %0t: %s gate got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_index(input forget_gate_pkg::row_t got,
                             input forget_gate_pkg::row_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      count_error();
      $display("[FAIL] %0t: %s index got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      count_error();
      $display("[FAIL] %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (test_errors == 0) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // Host load and run control
  //////////////////////////////////////////////////
  task automatic load_word(input int addr, input forget_gate_pkg::data_t data);
    @(posedge CLK);
    load_enable <= 1'b1;
    load_addr   <= forget_gate_pkg::addr_t'(addr);
    load_data   <= data;
    shadow[addr] = data;
  endtask

  task automatic load_idle();
    @(posedge CLK);
    load_enable <= 1'b0;
  endtask

  task automatic load_random_all();
    int l;
    int k;
    for (l = 0; l < forget_gate_pkg::MAX_L; l++) begin
      for (k = 0; k < forget_gate_pkg::MAX_N; k++) begin
        load_word(forget_gate_pkg::W_BASE + l * forget_gate_pkg::MAX_N + k, rand_operand());
      end
    end
    for (k = 0; k < forget_gate_pkg::MAX_N; k++) begin
      load_word(forget_gate_pkg::IN_BASE + k, rand_operand());
    end
    for (l = 0; l < forget_gate_pkg::MAX_L; l++) begin
      load_word(forget_gate_pkg::B_BASE + l, rand_operand());
    end
    load_idle();
  endtask

  // One-cycle START with sizes
  task automatic launch_run(input int l, input int n);
    @(posedge CLK);
    start  <= 1'b1;
    size_l <= forget_gate_pkg::cnt_t'(l);
    size_n <= forget_gate_pkg::len_t'(n);
    @(posedge CLK);
    start  <= 1'b0;
  endtask

  // Waits for READY, then checks count, order and values
  task automatic collect_run(input int l, input int n, input int base);
    int limit;
    int waited;
    int i;
    limit  = 3 * (l * (2 * n + 4) + 16);
    waited = 0;
    while (ready_count == base && waited < limit) begin
      @(negedge CLK);
      waited++;
    end
    if (ready_count == base) begin
      count_error();
      $display("READY missing: %0d-row run gave no READY in %0d cycles", l, limit);
    end else begin
      check_ready(ready_after_enable, 1'b1, "READY right after last gate");
    end
    // Catch late extras
    repeat (4) @(negedge CLK);
    if (ready_count > base + 1) begin
      count_error();
      $display("Extra READY: %0d pulses for one run", ready_count - base);
    end
    if (got_gate.size() != l) begin
      count_error();
      $display("Wrong output count: expected %0d gates, saw %0d", l, got_gate.size());
    end
    for (i = 0; i < l && i < got_gate.size(); i++) begin
      check_gate(got_gate[i], expected_gate(i, n), $sformatf("row %0d", i));
      check_index(got_index[i], forget_gate_pkg::row_t'(i), $sformatf("row %0d", i));
    end
  endtask

  task automatic run_and_check(input int l, input int n);
    int base;
    got_gate.delete();
    got_index.delete();
    base = ready_count;
    launch_run(l, n);
    collect_run(l, n, base);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic test_reset_idle();
    got_gate.delete();
    repeat (10) begin
      @(negedge CLK);
      check_ready(ready, 1'b0, "READY idle");
      check_ready(f_out_enable, 1'b0, "F_OUT_ENABLE idle");
    end
    if (got_gate.size() != 0) begin
      count_error();
      $display("Unexpected gate output with no START");
    end
    end_test("test 1 idle after reset");
  endtask

  // 1.0 * 0.5 + 0.25 lands mid-range
  task automatic test_single_row();
    load_word(forget_gate_pkg::W_BASE, 16'sd256);
    load_word(forget_gate_pkg::IN_BASE, 16'sd128);
    load_word(forget_gate_pkg::B_BASE, 16'sd64);
    load_idle();
    run_and_check(1, 1);
    end_test("test 2 single row");
  endtask

  task automatic test_full_random();
    load_random_all();
    run_and_check(8, 16);
    end_test("test 3 full 8x16 run");
  endtask

  task automatic test_clamp();
    load_word(forget_gate_pkg::B_BASE, 16'sh7F00);
    load_word(forget_gate_pkg::B_BASE + 1, 16'sh8000);
    load_idle();
    run_and_check(2, 16);
    if (got_gate.size() >= 2) begin
      check_gate(got_gate[0], 16'sd256, "upper clamp");
      check_gate(got_gate[1], 16'sd0, "lower clamp");
    end
    // Ordinary biases back for later runs
    load_word(forget_gate_pkg::B_BASE, rand_operand());
    load_word(forget_gate_pkg::B_BASE + 1, rand_operand());
    load_idle();
    end_test("test 4 clamping");
  endtask

  // Host writes two cycles in three, readers only get the gaps
  task automatic test_host_stall();
    int base;
    int phase;
    got_gate.delete();
    got_index.delete();
    base   = ready_count;
    phase  = 0;
    hammer = 1'b1;
    fork
      begin
        launch_run(8, 16);
        collect_run(8, 16, base);
        hammer = 1'b0;
      end
      begin
        while (hammer) begin
          @(posedge CLK);
          phase++;
          if (phase % 3 != 0) begin
            load_enable <= 1'b1;
            load_addr   <= forget_gate_pkg::addr_t'(250);
            load_data   <= forget_gate_pkg::data_t'(phase);
            shadow[250] = forget_gate_pkg::data_t'(phase);
          end else begin
            load_enable <= 1'b0;
          end
        end
        load_enable <= 1'b0;
      end
    join
    end_test("test 5 host stalls");
  endtask

  task automatic test_back_to_back();
    int base;
    got_gate.delete();
    got_index.delete();
    base = ready_count;
    launch_run(3, 5);
    // Second START lands mid-run
    repeat (4) @(posedge CLK);
    launch_run(8, 16);
    collect_run(3, 5, base);
    run_and_check(5, 12);
    end_test("test 6 back-to-back runs");
  endtask

  initial begin
    CLK                = 1'b0;
    RST                = 1'b1;
    load_enable        = 1'b0;
    load_addr          = '0;
    load_data          = '0;
    start              = 1'b0;
    size_l             = '0;
    size_n             = '0;
    ready_count        = 0;
    ready_after_enable = 1'b0;
    last_enable        = 1'b0;
    lcg_state          = 6;
    cycle_count        = 0;
    error_count        = 0;
    test_errors        = 0;
    check_count        = 0;
    test_count         = 0;
    hammer             = 1'b0;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (8) @(posedge CLK);
    RST <= 1'b0;

    test_reset_idle();
    test_single_row();
    test_full_random();
    test_clamp();
    test_host_stall();
    test_back_to_back();

    $display("Summary: %0d tests, %0d checks, %0d errors",
             test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/forget_gate_pkg.sv
design/operand_memory.sv
design/memory_arbiter.sv
design/dot_product_engine.sv
design/bias_logistic_unit.sv
design/gate_controller.sv
design/forget_gate_top.sv
sim/forget_gate_tb.sv

// ==== Bender.yml ====
package:
  name: forget_gate

sources:
  - design/forget_gate_pkg.sv
  - design/operand_memory.sv
  - design/memory_arbiter.sv
  - design/dot_product_engine.sv
  - design/bias_logistic_unit.sv
  - design/gate_controller.sv
  - design/forget_gate_top.sv
  - target: simulation
    files:
      - sim/forget_gate_tb.sv
